// File: src.f
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/cache_tag_state.sv
cache/cache_data_array.sv
cache/cache_dpath.sv
design/blocking_cache.sv
verification/blocking_cache_sva.sv
verification/tb_blocking_cache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_blocking_cache
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_blocking_cache.sv
/*
  Testbench for the blocking cache with a stalling memory model, a flat word
  model and a tag/LRU shadow, driven by directed test sequences
*/
`timescale 1ns/10ps

module tb_blocking_cache import cache_pkg::*; ();

  localparam int num_sets       = DEFAULT_NUM_SETS;
  localparam int random_count   = 200;
  localparam int directed_count = 20;
  localparam int timeout_cycles = 40 * (directed_count + random_count) + 10;

  logic        clk;
  logic        reset;
  logic        cachereq_val;
  logic        cachereq_rdy;
  cache_req_t  cachereq_msg;
  logic        cacheresp_val;
  logic        cacheresp_rdy;
  cache_resp_t cacheresp_msg;
  logic        memreq_val;
  logic        memreq_rdy;
  mem_req_t    memreq_msg;
  logic        memresp_val;
  logic        memresp_rdy;
  mem_resp_t   memresp_msg;

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [31:0] test_lfsr   = 32'h4ce;
  logic [31:0] mem_lfsr    = 32'h4ce;
  logic        stall_en    = 1'b0;
  logic [7:0]  opaque_q    = 8'h00;

  logic [LINE_W-1:0] mem_lines [line_addr_t];     // Lines written back so far
  logic [31:0]       ref_mem   [logic [31:0]];    // Last written word per address
  int                wb_count;
  line_addr_t        wb_addr;
  logic [LINE_W-1:0] wb_line;

  // Shadow tag state for hit prediction
  line_addr_t  model_tag   [num_sets][NUM_WAYS];
  logic [1:0]  model_valid [num_sets];
  logic        model_lru   [num_sets];

  blocking_cache #(.num_sets(num_sets)) blocking_cache_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_count++;

  initial begin : watchdog
    wait (cycle_count >= timeout_cycles);
    $display("Timeout: no progress after %0d cycles", cycle_count);
    $display("Checks failed");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, inout logic [31:0] state, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  // Initial memory content depends on the full word address
  function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic [LINE_W-1:0] mem_read_line(input line_addr_t line);
    logic [LINE_W-1:0] l;
    if (mem_lines.exists(line)) return mem_lines[line];
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[32*w +: 32] = mem_pattern({line, 2'(w), 2'b00});
    end
    return l;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : mem_pattern(addr);
  endfunction

  function automatic logic model_lookup(input logic [31:0] addr);
    logic [2:0] s;
    s = addr[6:4];
    return (model_valid[s][0] && model_tag[s][0] == addr[31:4]) ||
           (model_valid[s][1] && model_tag[s][1] == addr[31:4]);
  endfunction

  // Miss installs into the LRU way and every access moves LRU to the other way
  task automatic model_access(input logic [31:0] addr);
    logic [2:0] s;
    logic       way;
    s = addr[6:4];
    if (model_valid[s][1] && model_tag[s][1] == addr[31:4]) begin
      way = 1'b1;
    end else if (model_valid[s][0] && model_tag[s][0] == addr[31:4]) begin
      way = 1'b0;
    end else begin
      way = model_lru[s];
      model_valid[s][way] = 1'b1;
      model_tag[s][way]   = addr[31:4];
    end
    model_lru[s] = ~way;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One request through the cache (exp_hit below zero skips the hit check)
  task automatic do_access(input string name, input cache_op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input int exp_hit);
    cache_resp_t resp;
    logic [31:0] expected;
    logic [31:0] stall;
    expected = (op == op_read) ? ref_word(addr) : 32'h0;
    stall    = '0;
    if (stall_en) take_bits(2, test_lfsr, stall);
    cachereq_msg.op     = op;
    cachereq_msg.opaque = opaque_q;
    cachereq_msg.addr   = addr;
    cachereq_msg.data   = data;
    cachereq_val        = 1'b1;
    do @(negedge clk); while (!cachereq_rdy);
    next_cycle();
    cachereq_val = 1'b0;
    do @(negedge clk); while (!cacheresp_val);
    resp = cacheresp_msg;
    next_cycle();
    repeat (stall) next_cycle();       // Hold off the response
    cacheresp_rdy = 1'b1;
    next_cycle();
    cacheresp_rdy = 1'b0;
    check_value({name, " op"}, 32'(op), 32'(resp.op));
    check_value({name, " opaque"}, 32'(opaque_q), 32'(resp.opaque));
    check_value({name, " data"}, expected, resp.data);
    if (exp_hit >= 0) check_value({name, " hit"}, 32'(exp_hit), 32'(resp.hit));
    model_access(addr);
    if (op != op_read) ref_mem[addr] = data;
    opaque_q++;
  endtask

  // ------------------------------------------------------------------------
  // Memory model
  // ------------------------------------------------------------------------
  initial begin : memory_model
    mem_req_t    mreq;
    logic [31:0] stall;
    memreq_rdy  = 1'b1;
    memresp_val = 1'b0;
    memresp_msg = '0;
    wb_count    = 0;
    forever begin
      @(negedge clk);
      if (!reset && memreq_val && memreq_rdy) begin
        mreq = memreq_msg;
        next_cycle();
        memreq_rdy = 1'b0;
        if (mreq.op == mem_write) begin
          mem_lines[mreq.addr] = mreq.data;
          wb_count++;
          wb_addr = mreq.addr;
          wb_line = mreq.data;
        end
        stall = '0;
        if (stall_en) take_bits(2, mem_lfsr, stall);
        repeat (stall) next_cycle();
        memresp_msg.op   = mreq.op;
        memresp_msg.data = (mreq.op == mem_write) ? '0 : mem_read_line(mreq.addr);
        memresp_val      = 1'b1;
        do @(negedge clk); while (!memresp_rdy);
        next_cycle();
        memresp_val = 1'b0;
        memreq_rdy  = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Directed tests on sets 0 to 4
  // ------------------------------------------------------------------------
  task automatic init_then_read();
    do_access("init", op_init, 32'h2000, 32'hCAFE_0001, 0);
    do_access("init_read", op_read, 32'h2000, 32'h0, 1);
  endtask

  task automatic cold_read_then_reread();
    do_access("cold_read", op_read, 32'h2014, 32'h0, 0);
    do_access("reread", op_read, 32'h2018, 32'h0, 1);
  endtask

  task automatic write_hit_readback();
    do_access("write_fill", op_read, 32'h2020, 32'h0, 0);
    do_access("write_hit", op_write, 32'h2028, 32'h1234_5678, 1);
    for (int w = 0; w < 4; w++) begin
      do_access("write_readback", op_read, 32'h2020 + 32'(4 * w), 32'h0, 1);
    end
  endtask

  task automatic dirty_eviction();
    do_access("evict_write_a", op_write, 32'h3030, 32'hAAAA_0000, 0);
    do_access("evict_write_b", op_write, 32'h4034, 32'hBBBB_0001, 0);
    wb_count = 0;
    do_access("evict_read_c", op_read, 32'h5030, 32'h0, 0);
    check_value("evict count", 32'd1, 32'(wb_count));
    check_value("evict addr", 32'h0000_0303, 32'(wb_addr));
    for (int w = 0; w < 4; w++) begin
      check_value("evict line", ref_word(32'h3030 + 32'(4 * w)), wb_line[32*w +: 32]);
    end
    do_access("evict_reread_a", op_read, 32'h3030, 32'h0, 0);
  endtask

  task automatic lru_replacement();
    do_access("lru_fill_a", op_read, 32'h6040, 32'h0, 0);
    do_access("lru_fill_b", op_read, 32'h7040, 32'h0, 0);
    do_access("lru_touch_a", op_read, 32'h6040, 32'h0, 1);
    do_access("lru_read_c", op_read, 32'h8040, 32'h0, 0);
    do_access("lru_keep_a", op_read, 32'h6040, 32'h0, 1);
    do_access("lru_lost_b", op_read, 32'h7040, 32'h0, 0);
  endtask

  // Mixed traffic over sets 4 to 7 with memory and response stalls
  task automatic random_traffic();
    logic [31:0] sel;
    logic [31:0] tag;
    logic [31:0] set;
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] addr;
    cache_op_e   op;
    stall_en = 1'b1;
    for (int i = 0; i < random_count; i++) begin
      take_bits(2, test_lfsr, sel);
      take_bits(2, test_lfsr, tag);
      take_bits(2, test_lfsr, set);
      take_bits(2, test_lfsr, word);
      take_bits(32, test_lfsr, data);
      addr = 32'h0001_0000 | (tag << 7) | ((32'd4 + set) << 4) | (word << 2);
      case (sel[1:0])
        2'd2:    op = op_write;
        2'd3:    op = op_init;
        default: op = op_read;
      endcase
      // Init on a miss leaves the rest of the line unfetched
      if (op == op_init && !model_lookup(addr)) op = op_write;
      do_access("random", op, addr, data, -1);
    end
    stall_en = 1'b0;
  endtask

  initial begin : test_sequence
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_msg  = '0;
    cacheresp_rdy = 1'b0;
    for (int s = 0; s < num_sets; s++) begin
      model_valid[s] = '0;
      model_lru[s]   = 1'b0;
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    init_then_read();
    cold_read_then_reread();
    write_hit_readback();
    dirty_eviction();
    lru_replacement();
    random_traffic();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verification/blocking_cache_sva.sv
/*
  Handshake and latency assertions bound to the blocking cache top level
*/
`timescale 1ns/10ps

module blocking_cache_sva import cache_pkg::*; (
  input logic        clk,
  input logic        reset,
  input logic        cachereq_val,
  input logic        cachereq_rdy,
  input cache_req_t  cachereq_msg,
  input logic        cacheresp_val,
  input logic        cacheresp_rdy,
  input cache_resp_t cacheresp_msg,
  input logic        memreq_val,
  input logic        memreq_rdy,
  input mem_req_t    memreq_msg,
  input logic        memresp_val,
  input logic        memresp_rdy,
  input mem_resp_t   memresp_msg
);

  logic req_pending;   // Accepted request whose response is not yet taken

  always_ff @(posedge clk) begin
    if (reset) begin
      req_pending <= 1'b0;
    end else if (cachereq_val && cachereq_rdy) begin
      req_pending <= 1'b1;
    end else if (cacheresp_val && cacheresp_rdy) begin
      req_pending <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // A pending transfer keeps val and its message
  // ------------------------------------------------------------------------
  req_hold: assert property (@(posedge clk) disable iff (reset)
    cachereq_val && !cachereq_rdy |=> cachereq_val && $stable(cachereq_msg))
    else $error("cache request changed while waiting for rdy");

  resp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_msg))
    else $error("cache response changed while waiting for rdy");

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_msg))
    else $error("memory request changed while waiting for rdy");

  memresp_hold: assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val && $stable(memresp_msg))
    else $error("memory response changed while waiting for rdy");

  // Nothing outstanding once reset has been seen
  reset_quiet: assert property (@(posedge clk)
    reset |=> !cacheresp_val && !memreq_val)
    else $error("response or memory request valid after reset");

  busy_no_accept: assert property (@(posedge clk) disable iff (reset)
    req_pending |-> !cachereq_rdy)
    else $error("cache ready for a new request before the response was taken");

  // tag_check, init_access, then wait_resp
  init_latency: assert property (@(posedge clk) disable iff (reset)
    cachereq_val && cachereq_rdy && cachereq_msg.op == op_init
      |-> ##1 !cacheresp_val ##1 !cacheresp_val ##1 cacheresp_val)
    else $error("init response not exactly three cycles after acceptance");

endmodule

bind blocking_cache blocking_cache_sva blocking_cache_sva_inst (.*);

// File: design/blocking_cache.sv
/*
  Two-way set-associative blocking cache, write-back with write-allocate
*/
`timescale 1ns/10ps

module blocking_cache import cache_pkg::*; #(
  parameter int num_sets = DEFAULT_NUM_SETS  // Power of two
) (
  input  logic         clk,
  input  logic         reset,

  input  logic         cachereq_val,
  output logic         cachereq_rdy,
  input  cache_req_t   cachereq_msg,

  output logic         cacheresp_val,
  input  logic         cacheresp_rdy,
  output cache_resp_t  cacheresp_msg,

  output logic         memreq_val,
  input  logic         memreq_rdy,
  output mem_req_t     memreq_msg,

  input  logic         memresp_val,
  output logic         memresp_rdy,
  input  mem_resp_t    memresp_msg
);

  ctrl_sig_t           ctrl;
  tag_status_t         status;
  cache_req_t          req;
  logic [LINE_W-1:0]   line_rdata;
  logic [LINE_W-1:0]   line_wdata;
  logic [LINE_W/8-1:0] wben;

  cache_ctrl cache_ctrl_inst (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_op        (req.op),
    .status        (status),
    .ctrl          (ctrl)
  );

  cache_tag_state #(.num_sets(num_sets)) cache_tag_state_inst (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ctrl   (ctrl),
    .status (status)
  );

  cache_dpath cache_dpath_inst (
    .clk           (clk),
    .reset         (reset),
    .cachereq_msg  (cachereq_msg),
    .memresp_msg   (memresp_msg),
    .ctrl          (ctrl),
    .status        (status),
    .line_rdata    (line_rdata),
    .req           (req),
    .cacheresp_msg (cacheresp_msg),
    .memreq_msg    (memreq_msg),
    .line_wdata    (line_wdata),
    .wben          (wben)
  );

  // Way comes from the tag check, hit way or victim
  cache_data_array #(.num_sets(num_sets)) cache_data_array_inst (
    .clk      (clk),
    .reset    (reset),
    .req_addr (req.addr),
    .way      (status.way),
    .wen      (ctrl.data_wen),
    .wben     (wben),
    .wdata    (line_wdata),
    .rdata    (line_rdata)
  );

endmodule

// File: cache/cache_dpath.sv
/*
  Cache datapath: request and response registers, eviction and refill
  buffers, word select, write line merge and memory request build
*/
`timescale 1ns/10ps

module cache_dpath import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_req_t            cachereq_msg,
  input  mem_resp_t             memresp_msg,
  input  ctrl_sig_t             ctrl,
  input  tag_status_t           status,
  input  logic [LINE_W-1:0]     line_rdata,
  output cache_req_t            req,
  output cache_resp_t           cacheresp_msg,
  output mem_req_t              memreq_msg,
  output logic [LINE_W-1:0]     line_wdata,
  output logic [LINE_W/8-1:0]   wben
);

  localparam int word_w     = $clog2(WORDS_PER_LINE);
  localparam int word_bytes = DATA_W / 8;

  cache_req_t        req_q;
  cache_resp_t       resp_q;
  line_addr_t        evict_tag_q;
  logic [LINE_W-1:0] evict_line_q;
  logic [LINE_W-1:0] refill_line_q;
  logic              refilled_q;    // This request went through a refill
  logic [word_w-1:0] word_sel;
  logic [DATA_W-1:0] read_word;

  assign word_sel  = req_q.addr[OFFSET_W-1 -: word_w];
  assign read_word = line_rdata[word_sel*DATA_W +: DATA_W];

  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_q <= cachereq_msg;
    if (ctrl.evict_en) begin
      evict_line_q <= line_rdata;
      evict_tag_q  <= status.victim_tag;
    end
    // Keeps the last beat seen while waiting on memory
    if (ctrl.line_from_mem && !ctrl.data_wen) refill_line_q <= memresp_msg.data;
    if (ctrl.resp_en) begin
      resp_q.op     <= req_q.op;
      resp_q.opaque <= req_q.opaque;
      resp_q.hit    <= status.hit && !refilled_q;  // Same as the tag check result
      resp_q.data   <= (req_q.op == op_read) ? read_word : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      refilled_q <= 1'b0;
    end else if (ctrl.req_en) begin
      refilled_q <= 1'b0;
    end else if (ctrl.line_from_mem && ctrl.data_wen) begin
      refilled_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Write line and memory request
  // ------------------------------------------------------------------------
  always_comb begin
    wben = '0;
    if (ctrl.line_from_mem) begin
      line_wdata = refill_line_q;
      wben       = '1;
    end else begin
      line_wdata = {WORDS_PER_LINE{req_q.data}};
      wben[word_sel*word_bytes +: word_bytes] = '1;
    end
  end

  always_comb begin
    memreq_msg.op = ctrl.mem_op;
    if (ctrl.mem_op == mem_write) begin
      memreq_msg.addr = evict_tag_q;
      memreq_msg.data = evict_line_q;
    end else begin
      memreq_msg.addr = req_q.addr[ADDR_W-1:OFFSET_W];
      memreq_msg.data = '0;
    end
  end

  assign req           = req_q;
  assign cacheresp_msg = resp_q;

endmodule

// File: cache/cache_data_array.sv
/*
  Line storage for both ways, byte-enabled writes
  and combinational read of the addressed line
*/
`timescale 1ns/10ps

module cache_data_array import cache_pkg::*; #(
  parameter int num_sets = DEFAULT_NUM_SETS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ADDR_W-1:0]     req_addr,
  input  logic                  way,
  input  logic                  wen,
  input  logic [LINE_W/8-1:0]   wben,
  input  logic [LINE_W-1:0]     wdata,
  output logic [LINE_W-1:0]     rdata
);

  localparam int idx_w      = $clog2(num_sets);
  localparam int line_bytes = LINE_W / 8;

  logic [LINE_W-1:0] lines_q [num_sets*NUM_WAYS];
  logic [idx_w:0]    entry;

  // Set index and way form the entry number
  assign entry = {req_addr[OFFSET_W +: idx_w], way};

  assign rdata = lines_q[entry];

  always_ff @(posedge clk) begin
    if (wen && !reset) begin  // No stray writes while in reset
      for (int b = 0; b < line_bytes; b++) begin
        if (wben[b]) begin
          lines_q[entry][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: cache/cache_tag_state.sv
/*
  Tag, valid, dirty and LRU state for a two-way cache
  Detects hits and picks the victim way on a miss
*/
`timescale 1ns/10ps

module cache_tag_state import cache_pkg::*; #(
  parameter int num_sets = DEFAULT_NUM_SETS
) (
  input  logic        clk,
  input  logic        reset,
  input  cache_req_t  req,
  input  ctrl_sig_t   ctrl,
  output tag_status_t status
);

  localparam int idx_w = $clog2(num_sets);

  line_addr_t          tag_q   [num_sets][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_q [num_sets];
  logic [NUM_WAYS-1:0] dirty_q [num_sets];
  logic [num_sets-1:0] lru_q;               // Way to replace next

  logic [idx_w-1:0]    idx;
  line_addr_t          line_addr;
  logic [NUM_WAYS-1:0] match;
  logic                victim;
  logic                way;

  assign idx       = req.addr[OFFSET_W +: idx_w];
  assign line_addr = req.addr[ADDR_W-1:OFFSET_W];
  assign victim    = lru_q[idx];

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = valid_q[idx][w] && (tag_q[idx][w] == line_addr);
    end
  end

  assign way = (|match) ? match[1] : victim;

  assign status.hit          = |match;
  assign status.way          = way;
  assign status.victim_dirty = valid_q[idx][victim] && dirty_q[idx][victim];
  assign status.victim_tag   = tag_q[idx][victim];

  // Line address becomes the tag of the installed way
  always_ff @(posedge clk) begin
    if (ctrl.mark_valid) tag_q[idx][way] <= line_addr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
      lru_q <= '0;
    end else begin
      if (ctrl.mark_valid) valid_q[idx][way] <= 1'b1;
      if (ctrl.mark_dirty) begin
        dirty_q[idx][way] <= 1'b1;
      end else if (ctrl.clear_dirty) begin
        dirty_q[idx][way] <= 1'b0;
      end
      if (ctrl.touch_lru) lru_q[idx] <= ~way;  // Other way goes next
    end
  end

endmodule

// File: cache/cache_ctrl.sv
/*
  Blocking cache controller
  Sequences tag check, data access, dirty eviction and line refill
*/
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  input  logic        cachereq_val,
  output logic        cachereq_rdy,
  output logic        cacheresp_val,
  input  logic        cacheresp_rdy,

  output logic        memreq_val,
  input  logic        memreq_rdy,
  input  logic        memresp_val,
  output logic        memresp_rdy,

  input  cache_op_e   req_op,
  input  tag_status_t status,
  output ctrl_sig_t   ctrl
);

  ctrl_state_e state;
  ctrl_state_e state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (cachereq_val) state_next = tag_check;
      end
      tag_check: begin
        if (req_op == op_init) begin
          state_next = init_access;  // No fetch, line is overwritten in place
        end else if (status.hit) begin
          state_next = (req_op == op_write) ? write_access : read_access;
        end else if (status.victim_dirty) begin
          state_next = evict_prepare;
        end else begin
          state_next = refill_request;
        end
      end
      init_access:    state_next = wait_resp;
      read_access:    state_next = wait_resp;
      write_access:   state_next = wait_resp;
      evict_prepare:  state_next = evict_request;
      evict_request: begin
        if (memreq_rdy) state_next = evict_wait;
      end
      evict_wait: begin
        if (memresp_val) state_next = refill_request;  // Write ack from memory
      end
      refill_request: begin
        if (memreq_rdy) state_next = refill_wait;
      end
      refill_wait: begin
        if (memresp_val) state_next = refill_update;
      end
      refill_update: begin
        // Line now present, replay the access as a hit
        state_next = (req_op == op_write) ? write_access : read_access;
      end
      wait_resp: begin
        if (cacheresp_rdy) state_next = idle;
      end
      default:        state_next = idle;
    endcase
  end

  // ------------------------------------------------------------------------
  // Outputs per state
  // ------------------------------------------------------------------------
  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    ctrl          = '0;
    ctrl.mem_op   = mem_read;
    case (state)
      idle: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = 1'b1;
      end
      init_access: begin
        ctrl.data_wen   = 1'b1;
        ctrl.mark_valid = 1'b1;
        ctrl.mark_dirty = 1'b1;   // Init data exists only in the cache
        ctrl.touch_lru  = 1'b1;
        ctrl.resp_en    = 1'b1;
      end
      read_access: begin
        ctrl.touch_lru = 1'b1;
        ctrl.resp_en   = 1'b1;
      end
      write_access: begin
        ctrl.data_wen   = 1'b1;
        ctrl.mark_dirty = 1'b1;
        ctrl.touch_lru  = 1'b1;
        ctrl.resp_en    = 1'b1;
      end
      evict_prepare: begin
        ctrl.evict_en = 1'b1;     // Snapshot victim line and tag
      end
      evict_request: begin
        memreq_val  = 1'b1;
        ctrl.mem_op = mem_write;
      end
      evict_wait: begin
        memresp_rdy = 1'b1;
      end
      refill_request: begin
        memreq_val  = 1'b1;
        ctrl.mem_op = mem_read;
      end
      refill_wait: begin
        memresp_rdy        = 1'b1;
        ctrl.line_from_mem = 1'b1;  // Refill register follows memresp
      end
      refill_update: begin
        ctrl.data_wen      = 1'b1;
        ctrl.line_from_mem = 1'b1;
        ctrl.mark_valid    = 1'b1;
        ctrl.clear_dirty   = 1'b1;
      end
      wait_resp: begin
        cacheresp_val = 1'b1;
      end
      default: begin
        cachereq_rdy = 1'b0;
      end
    endcase
  end

endmodule

// File: common/cache_pkg.sv
/*
  Shared definitions for the two-way blocking cache: geometry, message
  layouts, tag check result and the control bundle
*/
package cache_pkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int ADDR_W           = 32;
  localparam int DATA_W           = 32;
  localparam int LINE_W           = 128;
  localparam int WORDS_PER_LINE   = 4;
  localparam int OFFSET_W         = 4;   // Byte offset within a line
  localparam int OPAQUE_W         = 8;
  localparam int NUM_WAYS         = 2;
  localparam int DEFAULT_NUM_SETS = 8;

  // Full line address doubles as the stored tag
  typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;

  typedef enum logic [2:0] {
    op_read  = 3'd0,
    op_write = 3'd1,
    op_init  = 3'd2
  } cache_op_e;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // ------------------------------------------------------------------------
  // Messages
  // ------------------------------------------------------------------------
  typedef struct packed {
    cache_op_e             op;
    logic [OPAQUE_W-1:0]   opaque;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     data;
  } cache_req_t;

  typedef struct packed {
    cache_op_e             op;
    logic [OPAQUE_W-1:0]   opaque;
    logic                  hit;
    logic [DATA_W-1:0]     data;
  } cache_resp_t;

  typedef struct packed {
    mem_op_e               op;
    line_addr_t            addr;
    logic [LINE_W-1:0]     data;
  } mem_req_t;

  typedef struct packed {
    mem_op_e               op;
    logic [LINE_W-1:0]     data;
  } mem_resp_t;

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    idle, tag_check, init_access, read_access, write_access,
    evict_prepare, evict_request, evict_wait,
    refill_request, refill_wait, refill_update, wait_resp
  } ctrl_state_e;

  typedef struct packed {
    logic                  hit;
    logic                  way;           // Hit way, else the victim
    logic                  victim_dirty;
    line_addr_t            victim_tag;
  } tag_status_t;

  typedef struct packed {
    logic                  req_en;
    logic                  data_wen;
    logic                  line_from_mem;
    logic                  mark_valid;
    logic                  mark_dirty;
    logic                  clear_dirty;
    logic                  touch_lru;
    logic                  evict_en;
    logic                  resp_en;
    mem_op_e               mem_op;
  } ctrl_sig_t;

endpackage
